//--- build.f
hdl/mul_cfg_pkg.sv
hdl/mul_types_pkg.sv
hdl/mul_if.sv
hdl/mul_operand_stage.sv
hdl/vedic_mul16.sv
hdl/vedic_mul32.sv
hdl/mul_result_stage.sv
hdl/simd_mul_top.sv
sim/simd_mul_assert.sv
sim/tb_simd_mul.sv

//--- sim/tb_simd_mul.sv
// ============================================================
// directed testbench for the SIMD multiplier
// reference model, scoreboard, handshake tasks, summary
// ============================================================
`timescale 1ns/1ps

module tb_simd_mul;
    import mul_cfg_pkg::*;
    import mul_types_pkg::*;

    localparam int TIMEOUT = 200;  // cycles allowed per wait

    logic         CLK, arst_n, in_valid, in_ready, out_valid, out_ready;
    mul_mode_e    in_mode;
    logic [31:0]  in_a, in_b, in_c, in_d;
    logic [7:0]   in_sign;
    logic [127:0] out_product;
    logic [127:0] exp_q[$];  // scoreboard in request order
    logic [31:0]  corner[4] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000};
    integer       seed = 32'h0a644b8a;
    int           err_count = 0;
    int           test_count = 0;

    simd_mul_top DUT (.*);

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    // exact products under the requested signedness
    function automatic logic [127:0] expected_product(mul_mode_e mode,
                                                      logic [31:0] a, b, c, d, logic [7:0] sg);
        logic [63:0]      ax, bx;
        logic [3:0][31:0] w;
        logic [31:0]      hx, lx;
        logic [127:0]     r;
        r = '0;
        if (mode == MODE_FULL32) begin
            ax = sg[1] ? {{32{a[31]}}, a} : {32'h0, a};
            bx = sg[0] ? {{32{b[31]}}, b} : {32'h0, b};
            r[63:0] = ax * bx;
        end else begin
            w = {d, c, b, a};
            for (int k = 0; k < 4; k++) begin
                hx = sg[2*k+1] ? {{16{w[k][31]}}, w[k][31:16]} : {16'h0, w[k][31:16]};
                lx = sg[2*k] ? {{16{w[k][15]}}, w[k][15:0]} : {16'h0, w[k][15:0]};
                r[32*k +: 32] = hx * lx;
            end
        end
        return r;
    endfunction

    task automatic check_eq(string name, logic [127:0] exp, logic [127:0] act);
        if (exp !== act) begin
            err_count++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic abort_run(string what);
        $display("timeout: %s did not happen within %0d cycles", what, TIMEOUT);
        $display("Testbench failed");
        $finish;
    endtask

    task automatic send_req(mul_mode_e mode, logic [31:0] a, b, c, d, logic [7:0] sg);
        int n;
        bit ok;
        n = 0;
        ok = 1'b0;
        @(negedge CLK);
        in_valid = 1'b1;
        in_mode  = mode;
        in_a     = a;
        in_b     = b;
        in_c     = c;
        in_d     = d;
        in_sign  = sg;
        exp_q.push_back(expected_product(mode, a, b, c, d, sg));
        while (!ok && n < TIMEOUT) begin
            @(posedge CLK);
            ok = in_ready;  // value before this edge
            n++;
        end
        if (!ok) abort_run("request accept");
    endtask

    task automatic get_rsp(string name, bit rand_ready, output int waited);
        bit           got;
        logic [127:0] act;
        got = 1'b0;
        waited = 0;
        while (!got && waited < TIMEOUT) begin
            @(negedge CLK);
            out_ready = rand_ready ? 1'($random(seed)) : 1'b1;
            @(posedge CLK);
            if (out_valid && !out_ready)
                check_eq({name, " in_ready while held"}, 128'h0, 128'(in_ready));
            got = out_valid && out_ready;
            act = out_product;
            if (!got) waited++;
        end
        if (!got)
            abort_run("result delivery");
        else
            check_eq(name, exp_q.pop_front(), act);
    endtask

    task automatic test_reset_latency();
        int n;
        int waited;
        check_eq("reset out_valid", 128'h0, 128'(out_valid));
        check_eq("reset in_ready", 128'h1, 128'(in_ready));
        send_req(MODE_FULL32, 32'h1234_5678, 32'h9abc_def0, 32'h0, 32'h0, 8'h03);
        @(negedge CLK);
        in_valid = 1'b0;
        n = 0;
        while (!out_valid && n < TIMEOUT) begin
            @(negedge CLK);
            n++;
        end
        check_eq("latency", 128'd3, 128'(n));
        get_rsp("latency", 1'b0, waited);  // result held until out_ready rises
        test_count++;
        $display("reset and latency: done");
    endtask

    // kind 0 full mode corners and random, 1 quad mode, 2 alternating modes
    task automatic run_batch(string name, int kind, int n, bit rand_ready);
        int          errs;
        int          waited;
        mul_mode_e   m;
        logic [7:0]  sg;
        logic [31:0] a, b, c, d;
        errs = err_count;
        fork
            begin
                for (int i = 0; i < n; i++) begin
                    m  = (kind == 1 || (kind == 2 && i % 2)) ? MODE_QUAD16 : MODE_FULL32;
                    sg = (kind == 0) ? 8'(i % 4) : 8'($random(seed));
                    a  = (kind == 0 && i < 64) ? corner[(i / 4) % 4] : $random(seed);
                    b  = (kind == 0 && i < 64) ? corner[(i / 16) % 4] : $random(seed);
                    c  = $random(seed);
                    d  = $random(seed);
                    send_req(m, a, b, c, d, sg);
                end
                @(negedge CLK);
                in_valid = 1'b0;
            end
            begin
                for (int j = 0; j < n; j++) begin
                    get_rsp(name, rand_ready, waited);
                    if (!rand_ready && j > 0)  // full pipeline gives one per cycle
                        check_eq({name, " gap"}, 128'h0, 128'(waited));
                end
            end
        join
        test_count++;
        $display("%s: %0d results, %0d errors", name, n, err_count - errs);
    endtask

    initial begin
        arst_n    = 1'b0;
        in_valid  = 1'b0;
        in_mode   = MODE_FULL32;
        in_a      = '0;
        in_b      = '0;
        in_c      = '0;
        in_d      = '0;
        in_sign   = '0;
        out_ready = 1'b0;
        repeat (16) @(posedge CLK);
        @(negedge CLK);
        arst_n = 1'b1;
        test_reset_latency();
        run_batch("full mode", 0, 96, 1'b0);
        run_batch("quad mode", 1, 40, 1'b0);
        run_batch("streaming", 2, 40, 1'b0);
        run_batch("back-pressure", 2, 60, 1'b1);
        err_count += DUT.u_assert.fail_count;  // failures of the bound assertions
        $display("%0d tests, %0d errors", test_count, err_count);
        if (err_count == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule : tb_simd_mul

//--- sim/simd_mul_assert.sv
// ============================================================
// concurrent assertions on the multiplier handshakes
// output hold under back-pressure, reset state, ready rule
// ============================================================
`timescale 1ns/1ps

module simd_mul_assert (
    input logic                                                   CLK,
    input logic                                                   arst_n,
    input logic                                                   in_ready,
    input logic                                                   out_valid,
    input logic                                                   out_ready,
    input logic [mul_cfg_pkg::LANES*mul_cfg_pkg::LANE_PROD_W-1:0] out_product
);

    int fail_count = 0;  // assertion failures so far

    // a held result keeps valid and data until it is taken
    property p_hold;
        @(posedge CLK) disable iff (!arst_n)
            out_valid && !out_ready |=> out_valid && $stable(out_product);
    endproperty
    a_hold: assert property (p_hold)
        else begin
            $error("result changed while held");
            fail_count++;
        end

    a_reset: assert property (@(posedge CLK) !arst_n |-> !out_valid)
        else begin
            $error("out_valid high during reset");
            fail_count++;
        end

    // empty output register always lets the pipeline advance
    a_ready: assert property (@(posedge CLK) disable iff (!arst_n) !out_valid |-> in_ready)
        else begin
            $error("in_ready low with empty output register");
            fail_count++;
        end

endmodule : simd_mul_assert

bind simd_mul_top simd_mul_assert u_assert (
    .CLK         (CLK),
    .arst_n      (arst_n),
    .in_ready    (in_ready),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_product (out_product)
);

//--- hdl/simd_mul_top.sv
// ============================================================
// SIMD integer multiplier top level
// operand stage, lane multipliers and result register
// ============================================================
`timescale 1ns/1ps

module simd_mul_top (
    input  logic                                            CLK,
    input  logic                                            arst_n,
    input  logic                                            in_valid,
    output logic                                            in_ready,
    input  mul_types_pkg::mul_mode_e                        in_mode,
    input  logic [mul_cfg_pkg::WORD_W-1:0]                  in_a,
    input  logic [mul_cfg_pkg::WORD_W-1:0]                  in_b,
    input  logic [mul_cfg_pkg::WORD_W-1:0]                  in_c,
    input  logic [mul_cfg_pkg::WORD_W-1:0]                  in_d,
    input  logic [2*mul_cfg_pkg::LANES-1:0]                 in_sign,
    output logic                                            out_valid,
    input  logic                                            out_ready,
    output logic [mul_cfg_pkg::LANES*mul_cfg_pkg::LANE_PROD_W-1:0] out_product
);

    lane_if lane_bus ();
    prod_if prod_bus ();

    mul_operand_stage u_operand (
        .CLK      (CLK),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_mode  (in_mode),
        .in_a     (in_a),
        .in_b     (in_b),
        .in_c     (in_c),
        .in_d     (in_d),
        .in_sign  (in_sign),
        .lanes    (lane_bus.src)
    );

    vedic_mul32 u_mul32 (
        .CLK    (CLK),
        .arst_n (arst_n),
        .lanes  (lane_bus.dst),
        .prods  (prod_bus.src)
    );

    mul_result_stage u_result (
        .CLK         (CLK),
        .arst_n      (arst_n),
        .prods       (prod_bus.dst),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_product (out_product)
    );

endmodule : simd_mul_top

//--- hdl/mul_result_stage.sv
// ============================================================
// output side: result register with valid/ready, and the
// pipeline advance for all stages before it
// ============================================================
`timescale 1ns/1ps

module mul_result_stage (
    input  logic                                            CLK,
    input  logic                                            arst_n,
    prod_if.dst                                             prods,
    output logic                                            out_valid,
    input  logic                                            out_ready,
    output logic [mul_cfg_pkg::LANES*mul_cfg_pkg::LANE_PROD_W-1:0] out_product
);
    import mul_cfg_pkg::*;
    import mul_types_pkg::*;

    logic advance;

    // register empty or being emptied this cycle
    assign advance     = !out_valid || out_ready;
    assign prods.ready = advance;

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= prods.valid;
        end
    end

    // product only loads with a real item
    always_ff @(posedge CLK) begin
        if (advance && prods.valid) begin
            if (prods.mode == MODE_FULL32) begin
                out_product <= {{(LANES*LANE_PROD_W-2*WORD_W){1'b0}}, prods.full64};
            end else begin
                out_product <= prods.lane_prod;  // lane k at 32k+31:32k
            end
        end
    end

endmodule : mul_result_stage

//--- hdl/vedic_mul32.sv
// ============================================================
// processing part: four 16x16 lanes, shadow pipeline for
// valid, mode and full mode signs, 64-bit recombination
// ============================================================
`timescale 1ns/1ps

module vedic_mul32 (
    input  logic CLK,
    input  logic arst_n,
    lane_if.dst  lanes,
    prod_if.src  prods
);
    import mul_cfg_pkg::*;
    import mul_types_pkg::*;

    logic [LANES-1:0][LANE_PROD_W-1:0] lane_prod;
    logic [MUL16_LAT-1:0]              valid_q;
    mul_mode_e                         mode_q  [MUL16_LAT];
    lane_sign_t                        fsign_q [MUL16_LAT];
    logic [2*WORD_W-1:0]               term0, term1, term2, term3;
    logic                              ext1, ext2;

    assign lanes.ready = prods.ready;  // advance travels backwards

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        vedic_mul16 u_mul16 (
            .CLK     (CLK),
            .arst_n  (arst_n),
            .en      (prods.ready),
            .a       (lanes.lane_a[i]),
            .b       (lanes.lane_b[i]),
            .sign    (lanes.lane_sign[i]),
            .product (lane_prod[i])
        );
    end

    // ============================================================
    // shadow pipeline, as deep as the lanes
    // ============================================================
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
            for (int k = 0; k < MUL16_LAT; k++) begin
                mode_q[k]  <= MODE_FULL32;
                fsign_q[k] <= '0;
            end
        end else if (prods.ready) begin
            valid_q    <= {valid_q[MUL16_LAT-2:0], lanes.valid};
            mode_q[0]  <= lanes.mode;
            fsign_q[0] <= lanes.full_sign;
            for (int k = 1; k < MUL16_LAT; k++) begin
                mode_q[k]  <= mode_q[k-1];
                fsign_q[k] <= fsign_q[k-1];
            end
        end
    end

    // lane 1 was aH x bL, lane 2 aL x bH
    assign ext1  = fsign_q[MUL16_LAT-1].a_signed & lane_prod[1][LANE_PROD_W-1];
    assign ext2  = fsign_q[MUL16_LAT-1].b_signed & lane_prod[2][LANE_PROD_W-1];
    assign term0 = {lane_prod[0], {WORD_W{1'b0}}};
    assign term1 = {{LANE_W{ext1}}, lane_prod[1], {LANE_W{1'b0}}};
    assign term2 = {{LANE_W{ext2}}, lane_prod[2], {LANE_W{1'b0}}};
    assign term3 = {{WORD_W{1'b0}}, lane_prod[3]};  // low lane never signed

    assign prods.valid     = valid_q[MUL16_LAT-1];
    assign prods.mode      = mode_q[MUL16_LAT-1];
    assign prods.lane_prod = lane_prod;
    assign prods.full64    = term0 + term1 + term2 + term3;

endmodule : vedic_mul32

//--- hdl/vedic_mul16.sv
// ============================================================
// 16x16 lane multiplier, vedic vertical and crosswise form
// per-operand signedness, two register stages
// ============================================================
`timescale 1ns/1ps

module vedic_mul16 (
    input  logic                                CLK,
    input  logic                                arst_n,
    input  logic                                en,
    input  logic [mul_cfg_pkg::LANE_W-1:0]      a,
    input  logic [mul_cfg_pkg::LANE_W-1:0]      b,
    input  mul_types_pkg::lane_sign_t           sign,
    output logic [mul_cfg_pkg::LANE_PROD_W-1:0] product
);
    import mul_cfg_pkg::*;

    logic                     a_neg, b_neg;
    logic [LANE_W-1:0]        a_mag, b_mag;
    logic [LANE_W/2-1:0]      a_hi, a_lo, b_hi, b_lo;
    logic [LANE_W-1:0]        pp_hh, pp_hl, pp_lh, pp_ll;  // 8x8 partials
    logic                     neg_q;
    logic [LANE_PROD_W-1:0]   sum;

    // magnitudes, -32768 still fits as unsigned 16 bits
    assign a_neg = sign.a_signed & a[LANE_W-1];
    assign b_neg = sign.b_signed & b[LANE_W-1];
    assign a_mag = a_neg ? -a : a;
    assign b_mag = b_neg ? -b : b;

    assign a_hi = a_mag[LANE_W-1:LANE_W/2];
    assign a_lo = a_mag[LANE_W/2-1:0];
    assign b_hi = b_mag[LANE_W-1:LANE_W/2];
    assign b_lo = b_mag[LANE_W/2-1:0];

    // ============================================================
    // stage 1: vertical and crosswise partial products
    // ============================================================
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            pp_hh <= '0;
            pp_hl <= '0;
            pp_lh <= '0;
            pp_ll <= '0;
            neg_q <= 1'b0;
        end else if (en) begin
            pp_hh <= a_hi * b_hi;  // vertical, high
            pp_hl <= a_hi * b_lo;  // crosswise
            pp_lh <= a_lo * b_hi;  // crosswise
            pp_ll <= a_lo * b_lo;  // vertical, low
            neg_q <= a_neg ^ b_neg;
        end
    end

    // the crosswise terms share one weight
    assign sum = (LANE_PROD_W'(pp_hh) << LANE_W)
               + (LANE_PROD_W'(pp_hl) << (LANE_W/2))
               + (LANE_PROD_W'(pp_lh) << (LANE_W/2))
               + LANE_PROD_W'(pp_ll);

    // ============================================================
    // stage 2: sum and sign
    // ============================================================
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            product <= '0;
        end else if (en) begin
            product <= neg_q ? -sum : sum;
        end
    end

endmodule : vedic_mul16

//--- hdl/mul_operand_stage.sv
// ============================================================
// input side of the multiplier
// accepts a request and registers it steered into four
// lane operand pairs with their sign flags
// ============================================================
`timescale 1ns/1ps

module mul_operand_stage (
    input  logic                               CLK,
    input  logic                               arst_n,
    input  logic                               in_valid,
    output logic                               in_ready,
    input  mul_types_pkg::mul_mode_e           in_mode,
    input  logic [mul_cfg_pkg::WORD_W-1:0]     in_a,
    input  logic [mul_cfg_pkg::WORD_W-1:0]     in_b,
    input  logic [mul_cfg_pkg::WORD_W-1:0]     in_c,
    input  logic [mul_cfg_pkg::WORD_W-1:0]     in_d,
    input  logic [2*mul_cfg_pkg::LANES-1:0]    in_sign,
    lane_if.src                                lanes
);
    import mul_cfg_pkg::*;
    import mul_types_pkg::*;

    logic [LANES-1:0][WORD_W-1:0]  words;      // quad mode input words
    logic [LANES-1:0][LANE_W-1:0]  steer_a;
    logic [LANES-1:0][LANE_W-1:0]  steer_b;
    lane_sign_t [LANES-1:0]        steer_sign;
    lane_sign_t                    full_sign;

    assign in_ready  = lanes.ready;
    assign words     = {in_d, in_c, in_b, in_a};
    assign full_sign = in_sign[1:0];  // full mode uses the lane 0 flag pair

    // ============================================================
    // operand steering
    // ============================================================
    always_comb begin
        if (in_mode == MODE_FULL32) begin
            steer_a[0]    = in_a[WORD_W-1:LANE_W];  // aH x bH
            steer_b[0]    = in_b[WORD_W-1:LANE_W];
            steer_sign[0] = full_sign;
            steer_a[1]    = in_a[WORD_W-1:LANE_W];  // aH x bL
            steer_b[1]    = in_b[LANE_W-1:0];
            steer_sign[1] = {full_sign.a_signed, 1'b0};
            steer_a[2]    = in_a[LANE_W-1:0];       // aL x bH
            steer_b[2]    = in_b[WORD_W-1:LANE_W];
            steer_sign[2] = {1'b0, full_sign.b_signed};
            steer_a[3]    = in_a[LANE_W-1:0];       // aL x bL, always unsigned
            steer_b[3]    = in_b[LANE_W-1:0];
            steer_sign[3] = 2'b00;
        end else begin
            // each lane: upper half times lower half of its own word
            for (int k = 0; k < LANES; k++) begin
                steer_a[k]    = words[k][WORD_W-1:LANE_W];
                steer_b[k]    = words[k][LANE_W-1:0];
                steer_sign[k] = in_sign[2*k +: 2];
            end
        end
    end

    // ============================================================
    // stage register
    // ============================================================
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            lanes.valid <= 1'b0;
            lanes.mode  <= MODE_FULL32;
        end else if (lanes.ready) begin
            lanes.valid <= in_valid;  // bubble when nothing is offered
            lanes.mode  <= in_mode;
        end
    end

    always_ff @(posedge CLK) begin
        if (lanes.ready && in_valid) begin
            lanes.lane_a    <= steer_a;
            lanes.lane_b    <= steer_b;
            lanes.lane_sign <= steer_sign;
            lanes.full_sign <= full_sign;
        end
    end

endmodule : mul_operand_stage

//--- hdl/mul_if.sv
// ============================================================
// lane_if  steered operands into the lane multipliers
// prod_if  lane products and full product to the output side
// ============================================================
`timescale 1ns/1ps

interface lane_if;
    import mul_cfg_pkg::*;
    import mul_types_pkg::*;

    logic                           valid;
    mul_mode_e                      mode;
    logic [LANES-1:0][LANE_W-1:0]   lane_a;
    logic [LANES-1:0][LANE_W-1:0]   lane_b;
    lane_sign_t [LANES-1:0]         lane_sign;
    lane_sign_t                     full_sign;  // signs of the whole 32-bit pair
    logic                           ready;      // pipeline advance

    modport src (output valid, mode, lane_a, lane_b, lane_sign, full_sign, input ready);
    modport dst (input valid, mode, lane_a, lane_b, lane_sign, full_sign, output ready);
endinterface : lane_if

interface prod_if;
    import mul_cfg_pkg::*;
    import mul_types_pkg::*;

    logic                               valid;
    mul_mode_e                          mode;
    logic [LANES-1:0][LANE_PROD_W-1:0]  lane_prod;
    logic [2*WORD_W-1:0]                full64;  // recombined full mode product
    logic                               ready;

    modport src (output valid, mode, lane_prod, full64, input ready);
    modport dst (input valid, mode, lane_prod, full64, output ready);
endinterface : prod_if

//--- hdl/mul_types_pkg.sv
// ============================================================
// types of the SIMD multiplier
// mode opcode and per-lane operand sign flags
// ============================================================

package mul_types_pkg;

    // operation mode of one request
    typedef enum logic {
        MODE_FULL32 = 1'b0,  // one 32x32 product, 64 bits
        MODE_QUAD16 = 1'b1   // four independent 16x16 products
    } mul_mode_e;

    // how the two operands of one lane are treated
    // a_signed is bit 1 and b_signed bit 0, so two request bits map directly
    typedef struct packed {
        logic a_signed;  // multiplicand is two's complement
        logic b_signed;  // multiplier is two's complement
    } lane_sign_t;

endpackage : mul_types_pkg

//--- hdl/mul_cfg_pkg.sv
// ============================================================
// sizes and timing of the SIMD multiplier
// lane count, operand and product widths, lane latency
// ============================================================

package mul_cfg_pkg;

    // ============================================================
    // datapath widths
    // ============================================================
    localparam int LANES       = 4;   // 16x16 lanes in the multiplier
    localparam int LANE_W      = 16;  // lane operand width
    localparam int WORD_W      = 32;  // full mode operand width
    localparam int LANE_PROD_W = 32;  // lane product width

    // ============================================================
    // timing
    // ============================================================
    // register stages inside one lane multiplier
    localparam int MUL16_LAT   = 2;

endpackage : mul_cfg_pkg
